/* bridge_trace.txt */
# op addr(hex) count bytes(hex): W data written, R bytes expected on miso
# C expected ctrl[0] to ctrl[3], its address is unused
C 00000000 4 00 00 00 00
W 00000000 4 a1 b2 c3 d4
R 00000000 4 a1 b2 c3 d4
W 00000002 1 ee
R 00000000 4 a1 b2 c3 d4
W 00000021 5 11 22 33 44 55
R 00000021 5 11 22 33 44 55
R 00000000 4 a1 b2 c3 d4
W ff000000 4 5a 01 c3 80
C 00000000 4 5a 01 c3 80
R ff000000 4 5a 01 c3 80
R ff000002 2 c3 80
W 12000000 2 77 66
R 12000000 2 00 00
R 00000000 2 a1 b2
C 00000000 4 5a 01 c3 80

/* vlog.f */
+incdir+.
spi_pkg.sv
mem_pkg.sv
spi_byte_slave.sv
word_packer.sv
ctrl_reg_bank.sv
word_ram.sv
read_merge.sv
spi_mem_bridge_top.sv
spi_bridge_assertions.sv
tb_spi_mem_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run from the project root, decide on the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_spi_mem_bridge -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log \
  && grep -qx "Test passed" sim.log \
  && exit 0 || exit 1

/* tb_spi_mem_bridge.sv */
`include "spirw_cfg.svh"

module tb_spi_mem_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import spi_pkg::*;
  import mem_pkg::*;

  logic       clk;
  logic       rst_n;
  logic       spi_csn;
  logic       spi_sclk;
  logic       spi_mosi;
  logic       spi_miso;
  ctrl_regs_t ctrl;

  // one entry per trace line, bytes kept flat
  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  int          cnt_q[$];
  int          base_q[$];   // first byte of the line in byte_q
  spi_byte_t   byte_q[$];

  int     n_pass;
  int     n_fail;
  int     test_err;   // mismatches in the running test
  bit     loaded;
  longint wd_limit;   // ns

  spi_mem_bridge_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_csn  (spi_csn),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .ctrl     (ctrl)
  );

  always #2 clk = ~clk; // 4 ns period

  // n rising edges, then step off the edge before driving
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input string what, input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, what, got, exp);
      n_fail++;
      test_err++;
    end
    else
      n_pass++;
  endtask

  task automatic check_ctrl(input string what, input ctrl_regs_t got, input ctrl_regs_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, what, got, exp);
      n_fail++;
      test_err++;
    end
    else
      n_pass++;
  endtask

  // mode 0, msb first, sclk = clk/16
  task automatic spi_byte(input spi_byte_t tx, output spi_byte_t rx);
    for (int i = 7; i >= 0; i--)
    begin
      spi_sclk = 1'b0; // slave shifts miso on this fall
      spi_mosi = tx[i];
      wait_clks(8);
      rx[i]    = spi_miso; // master samples at the rise
      spi_sclk = 1'b1;
      wait_clks(8);
    end
  endtask

  task automatic send_header(input spi_byte_t cmd, input logic [31:0] a);
    spi_byte_t rx;
    spi_byte(cmd, rx);
    for (int k = 3; k >= 0; k--)
      spi_byte(a[k*8 +: 8], rx); // address msb first
  endtask

  task automatic run_test(input int t);
    logic [7:0]  op;
    logic [31:0] a;
    int          n;
    int          base;
    spi_byte_t   rx;
    ctrl_regs_t  exp;
    op       = op_q[t];
    a        = addr_q[t];
    n        = cnt_q[t];
    base     = base_q[t];
    test_err = 0;
    if (op == "C")
    begin
      for (int i = 0; i < `SPIRW_CTRL_REGS; i++)
        exp[i] = (i < n) ? byte_q[base + i] : 8'h00; // index 0 first in the trace
      check_ctrl("ctrl", ctrl, exp);
    end
    else
    begin
      spi_csn = 1'b0;
      wait_clks(4);
      send_header((op == "R") ? SPI_CMD_READ : SPI_CMD_WRITE, a);
      for (int k = 0; k < n; k++)
      begin
        if (op == "R")
        begin
          spi_byte(8'h00, rx);
          check_byte($sformatf("spi_miso @%h", a + k), rx, byte_q[base + k]);
        end
        else
          spi_byte(byte_q[base + k], rx);
      end
      spi_sclk = 1'b0;
      wait_clks(8);
      spi_csn = 1'b1; // ends the transaction
      wait_clks(16);
    end
    if (test_err == 0)
      $display("test %0d: %s %h, %0d bytes, ok", t, op, a, n);
    else
      $display("test %0d: %s %h, %0d bytes, %0d mismatches", t, op, a, n, test_err);
  endtask

  // op char, hex address, byte count, hex bytes; '#' lines skipped
  task automatic load_trace(output bit ok);
    int          fd;
    int          c;
    int          r;
    int          n;
    logic [31:0] a;
    spi_byte_t   b;
    ok = 1'b0;
    fd = $fopen("bridge_trace.txt", "r");
    if (fd == 0)
      return;
    c = $fgetc(fd);
    while (c != -1)
    begin
      if (c == "#")
      begin
        while (c != -1 && c != "\n")
          c = $fgetc(fd);
      end
      else if (c == "W" || c == "R" || c == "C")
      begin
        r = $fscanf(fd, "%h %d", a, n);
        if (r != 2)
          n = 0; // malformed line, nothing queued for it
        op_q.push_back(8'(c));
        addr_q.push_back(a);
        cnt_q.push_back(n);
        base_q.push_back(byte_q.size());
        for (int k = 0; k < n; k++)
        begin
          r = $fscanf(fd, "%h", b);
          byte_q.push_back(b);
        end
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    ok = (op_q.size() > 0);
  endtask

  initial
  begin
    bit ok;
    clk      = 1'b0;
    rst_n    = 1'b0;
    spi_csn  = 1'b1; // deselected
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    n_pass   = 0;
    n_fail   = 0;
    loaded   = 1'b0;
    load_trace(ok);
    if (!ok)
    begin
      $display("could not read any transaction from bridge_trace.txt");
      $display("Test failed");
    end
    else
    begin
      // (bytes + 5 per transaction) x 8 bits x 16 clk x 4 ns, doubled
      wd_limit = longint'(byte_q.size() + 5 * op_q.size()) * 8 * 16 * 4 * 2;
      loaded   = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      wait_clks(4);
      for (int t = 0; t < op_q.size(); t++)
        run_test(t);
      $display("%0d tests, %0d checks ok, %0d checks bad", op_q.size(), n_pass, n_fail);
      if (n_fail == 0)
        $display("Test passed");
      else
        $display("Test failed");
    end
    $finish;
  end

  // watchdog, armed once the trace length is known
  initial
  begin
    wait (loaded);
    #(wd_limit);
    $display("watchdog expired after %0d ns, the trace did not finish", wd_limit);
    $display("Test failed");
    $finish;
  end

endmodule

/* spi_bridge_assertions.sv */
module spi_bridge_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input spi_pkg::byte_access_t bus,
  input mem_pkg::word_req_t    req,
  input mem_pkg::ctrl_regs_t   ctrl
);
  timeunit 1ns;
  timeprecision 100ps;

  logic strobe; // any strobe on byte or word bus

  assign strobe = bus.rd | bus.wr | req.we | req.re;

  // one byte access per cycle
  a_rd_wr: assert property (@(posedge clk) disable iff (!rst_n) !(bus.rd && bus.wr))
    else $error("rd and wr strobes high in the same cycle");

  a_we_re: assert property (@(posedge clk) disable iff (!rst_n) !(req.we && req.re))
    else $error("ram we and re high in the same cycle");

  // held in reset, bus quiet and control cleared
  a_rst_quiet: assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> !strobe && ctrl == '0)
    else $error("strobe or nonzero ctrl while in reset");

  a_ctrl_rst: assert property (@(posedge clk) $rose(rst_n) |-> ctrl == '0)
    else $error("ctrl not zero when reset is released");

endmodule

bind spi_mem_bridge_top spi_bridge_assertions u_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .bus   (bus),
  .req   (req),
  .ctrl  (ctrl)
);

/* spi_mem_bridge_top.sv */
module spi_mem_bridge_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                spi_csn,
  input  logic                spi_sclk,
  input  logic                spi_mosi,
  output logic                spi_miso,
  output mem_pkg::ctrl_regs_t ctrl
);
  import spi_pkg::*;
  import mem_pkg::*;

  byte_access_t bus;       // decoded byte bus, fans out three ways
  spi_byte_t    rd_byte;   // merged read byte back to the slave
  word_req_t    req;       // packer to ram
  mem_word_t    ram_word;

  spi_byte_slave u_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_csn  (spi_csn),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .bus      (bus),
    .rdata    (rd_byte)
  );

  // memory path
  word_packer u_packer (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .req   (req)
  );

  word_ram u_ram (
    .clk   (clk),
    .req   (req),
    .rdata (ram_word)
  );

  // control path, side by side with the packer
  ctrl_reg_bank u_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .ctrl  (ctrl)
  );

  read_merge u_merge (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .word  (ram_word),
    .ctrl  (ctrl),
    .rdata (rd_byte)
  );

endmodule

/* read_merge.sv */
`include "spirw_cfg.svh"

module read_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_pkg::byte_access_t bus,
  input  mem_pkg::mem_word_t    word,
  input  mem_pkg::ctrl_regs_t   ctrl,
  output spi_pkg::spi_byte_t    rdata
);
  import spi_pkg::*;

  localparam int IDX_W = $clog2(`SPIRW_CTRL_REGS);

  // what a read was aimed at, carried along the ram latency
  typedef struct packed {
    logic             vld;
    logic             is_mem;
    logic             is_ctrl;
    logic             lane;     // addr[0]
    logic [IDX_W-1:0] idx;      // ctrl register
  } rd_tag_t;

  rd_tag_t   tag_in, tag_s1, tag_s2;
  spi_byte_t sel;

  always_comb
  begin
    tag_in.vld     = bus.rd;
    tag_in.is_mem  = (bus.addr[`SPIRW_ADDR_BITS-1 -: 8] == `SPIRW_REGION_MEM);
    tag_in.is_ctrl = (bus.addr[`SPIRW_ADDR_BITS-1 -: 8] == `SPIRW_REGION_CTRL);
    tag_in.lane    = bus.addr[0];
    tag_in.idx     = bus.addr[IDX_W-1:0];
  end

  // s1 lines up with re, s2 with the ram word
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tag_s1 <= '0;
      tag_s2 <= '0;
      rdata  <= '0;
    end
    else
    begin
      tag_s1 <= tag_in;
      tag_s2 <= tag_s1;
      if (tag_s2.vld)
        rdata <= sel; // 3 cycles after rd
    end
  end

  always_comb
  begin
    if (tag_s2.is_mem)
      sel = tag_s2.lane ? word[7:0] : word[15:8];
    else if (tag_s2.is_ctrl)
      sel = ctrl[tag_s2.idx];
    else
      sel = 8'h00; // unmapped region reads zero
  end

endmodule

/* word_ram.sv */
`include "spirw_cfg.svh"

module word_ram (
  input  logic               clk,
  input  mem_pkg::word_req_t req,
  output mem_pkg::mem_word_t rdata
);
  import mem_pkg::*;

  localparam int DEPTH = 2 ** `SPIRW_MEM_AW;

  // stands in for the sdram chip, contents undefined at start
  mem_word_t mem [0:DEPTH-1];

  always_ff @(posedge clk)
  begin
    if (req.we)
      mem[req.addr] <= req.wdata;
  end

  // registered read, one cycle after re
  always_ff @(posedge clk)
  begin
    if (req.re)
      rdata <= mem[req.addr]; // holds until the next re
  end

endmodule

/* ctrl_reg_bank.sv */
`include "spirw_cfg.svh"

module ctrl_reg_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_pkg::byte_access_t bus,
  output mem_pkg::ctrl_regs_t   ctrl
);

  localparam int IDX_W = $clog2(`SPIRW_CTRL_REGS);

  logic             hit;   // write into region 0xff
  logic [IDX_W-1:0] idx;   // register select from low address bits

  assign hit = bus.wr && (bus.addr[`SPIRW_ADDR_BITS-1 -: 8] == `SPIRW_REGION_CTRL);
  assign idx = bus.addr[IDX_W-1:0];

  // control state, also the output port
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ctrl <= '0;
    else if (hit)
      ctrl[idx] <= bus.data; // visible one cycle after wr
  end

endmodule

/* word_packer.sv */
`include "spirw_cfg.svh"

module word_packer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_pkg::byte_access_t bus,
  output mem_pkg::word_req_t    req
);
  import spi_pkg::*;

  localparam int AW = `SPIRW_MEM_AW;

  logic          in_mem;    // region 0x00 hit
  logic          odd_wr;    // second byte of a pair
  spi_byte_t     lane_hi;   // even byte
  spi_byte_t     lane_lo;   // odd byte
  logic          we_q, re_q;
  logic [AW-1:0] addr_q;

  assign in_mem = (bus.addr[`SPIRW_ADDR_BITS-1 -: 8] == `SPIRW_REGION_MEM);
  assign odd_wr = bus.wr & in_mem & bus.addr[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      we_q <= 1'b0;
      re_q <= 1'b0;
    end
    else
    begin
      we_q <= odd_wr;          // even byte alone never commits
      re_q <= bus.rd & in_mem; // every byte read fetches the whole word
    end
  end

  always_ff @(posedge clk)
  begin
    if (bus.wr & in_mem)
    begin
      if (bus.addr[0])
        lane_lo <= bus.data;
      else
        lane_hi <= bus.data;
    end
    if (odd_wr | (bus.rd & in_mem))
      addr_q <= bus.addr[AW:1]; // drop byte lane
  end

  always_comb
  begin
    req.we    = we_q;
    req.re    = re_q;
    req.addr  = addr_q;
    req.wdata = {lane_hi, lane_lo}; // even byte high
  end

endmodule

/* spi_byte_slave.sv */
`include "spirw_cfg.svh"

module spi_byte_slave (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 spi_csn,
  input  logic                 spi_sclk,
  input  logic                 spi_mosi,
  output logic                 spi_miso,
  output spi_pkg::byte_access_t bus,
  input  spi_pkg::spi_byte_t   rdata
);
  import spi_pkg::*;

  localparam int AB = `SPIRW_ADDR_BITS;

  typedef struct packed {
    logic csn;
    logic sclk;
    logic mosi;
  } pins_t;

  typedef enum logic [1:0] {S_IDLE, S_CMD, S_ADDR, S_DATA} state_t;

  pins_t          pin_m, pin_s;   // two-flop synchronizer
  logic           sclk_d;         // for edge detect
  logic           sclk_rise, sclk_fall;
  logic [2:0]     bit_cnt;
  logic           byte_done;      // one cycle after the 8th rise
  spi_byte_t      rx_sh;
  spi_byte_t      tx_sh;
  state_t         state;
  spi_cmd_t       cmd;
  logic [1:0]     addr_cnt;       // address bytes seen so far
  logic [AB-1:0]  addr;           // address of current byte
  logic [AB-1:0]  addr_in, addr_inc;
  logic [2:0]     rd_dly;         // rd strobe age

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pin_m  <= '{csn: 1'b1, sclk: 1'b0, mosi: 1'b0}; // idle bus, deselected
      pin_s  <= '{csn: 1'b1, sclk: 1'b0, mosi: 1'b0};
      sclk_d <= 1'b0;
    end
    else
    begin
      pin_m  <= '{csn: spi_csn, sclk: spi_sclk, mosi: spi_mosi};
      pin_s  <= pin_m;
      sclk_d <= pin_s.sclk;
    end
  end

  assign sclk_rise = pin_s.sclk & ~sclk_d & ~pin_s.csn;
  assign sclk_fall = ~pin_s.sclk & sclk_d & ~pin_s.csn;

  // bit counter, partial byte dropped when csn rises
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end
    else if (pin_s.csn)
    begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end
    else
    begin
      byte_done <= sclk_rise && (bit_cnt == 3'd7);
      if (sclk_rise)
        bit_cnt <= bit_cnt + 3'd1; // wraps at 8
    end
  end

  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      rx_sh <= {rx_sh[6:0], pin_s.mosi}; // msb first
  end

  assign addr_in  = {addr[AB-9:0], rx_sh}; // next address byte shifted in
  assign addr_inc = addr + 1'b1;

  // command / address / data sequencing, strobes land two cycles after the rise
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      cmd      <= SPI_CMD_WRITE;
      addr_cnt <= '0;
      addr     <= '0;
      bus      <= '0;
    end
    else
    begin
      bus.rd <= 1'b0;
      bus.wr <= 1'b0;
      if (pin_s.csn)
        state <= S_IDLE;
      else if (state == S_IDLE)
        state <= S_CMD; // csn just fell
      else if (byte_done)
      begin
        case (state)
          S_CMD:
          begin
            cmd      <= spi_cmd_t'(rx_sh);
            addr_cnt <= '0;
            state    <= S_ADDR;
          end
          S_ADDR:
          begin
            addr     <= addr_in;
            addr_cnt <= addr_cnt + 2'd1;
            if (addr_cnt == 2'd3)
            begin
              state <= S_DATA;
              if (cmd == SPI_CMD_READ)
              begin
                bus.rd   <= 1'b1; // prefetch first read byte
                bus.addr <= addr_in;
              end
            end
          end
          S_DATA:
          begin
            addr <= addr_inc; // auto increment
            if (cmd == SPI_CMD_READ)
            begin
              bus.rd   <= 1'b1;
              bus.addr <= addr_inc;
            end
            else if (cmd == SPI_CMD_WRITE)
            begin
              bus.wr   <= 1'b1;
              bus.addr <= addr;
              bus.data <= rx_sh;
            end
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // read data comes back 3 cycles after rd, out on falling edges
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_dly   <= '0;
      tx_sh    <= '0;
      spi_miso <= 1'b0;
    end
    else
    begin
      rd_dly <= {rd_dly[1:0], bus.rd};
      if (pin_s.csn)
      begin
        tx_sh    <= '0;
        spi_miso <= 1'b0;
      end
      else
      begin
        if (sclk_fall)
        begin
          spi_miso <= tx_sh[7];
          tx_sh    <= {tx_sh[6:0], 1'b0};
        end
        if (rd_dly[2])
          tx_sh <= rdata; // ready before the next fall
      end
    end
  end

endmodule

/* mem_pkg.sv */
`include "spirw_cfg.svh"

package mem_pkg;

  // one word of the ram, even byte in the high half
  typedef logic [15:0] mem_word_t;

  // request into the word ram
  // we and re are single-cycle strobes and never overlap
  typedef struct packed {
    logic                     we;    // commit wdata at addr
    logic                     re;    // read word, data next cycle
    logic [`SPIRW_MEM_AW-1:0] addr;  // word address
    mem_word_t                wdata;
  } word_req_t;

  // control bytes, index 0 is register 0xff000000
  typedef logic [`SPIRW_CTRL_REGS-1:0][7:0] ctrl_regs_t;

endpackage

/* spi_pkg.sv */
`include "spirw_cfg.svh"

package spi_pkg;

  // first byte of every transaction
  typedef enum logic [7:0] {
    SPI_CMD_WRITE = 8'h00,
    SPI_CMD_READ  = 8'h01
  } spi_cmd_t;

  // one data byte on the wire
  typedef logic [7:0] spi_byte_t;

  // decoded byte bus out of the slave
  // rd and wr are single-cycle strobes, no back-pressure
  typedef struct packed {
    logic                        rd;   // fetch byte at addr
    logic                        wr;   // store data at addr
    logic [`SPIRW_ADDR_BITS-1:0] addr; // byte address, region in top byte
    spi_byte_t                   data; // write data, valid with wr
  } byte_access_t;

endpackage

/* spirw_cfg.svh */
`ifndef SPIRW_CFG_SVH
`define SPIRW_CFG_SVH

// spi side address, full byte address sent by the master
`define SPIRW_ADDR_BITS 32

// word ram, 2**10 words of 16 bits
`define SPIRW_MEM_AW 10

// region codes live in address bits 31..24
`define SPIRW_REGION_MEM  8'h00
`define SPIRW_REGION_CTRL 8'hFF

// control bytes in region 0xff, also driven out of the top
`define SPIRW_CTRL_REGS 4

`endif
